//--- rtl/video_pkg.sv
`default_nettype none

package video_pkg;

  // raster coordinate as delivered by the timing generator
  typedef logic [10:0] coord_t;

  // 4-4-4 colour
  typedef logic [11:0] rgb_t;

  // playfield origin on screen
  localparam coord_t grid_x0 = 11'd201;
  localparam coord_t grid_y0 = 11'd10;

  // one cell is a square of cell_size pixels
  localparam coord_t cell_size = 11'd35;
  localparam coord_t bevel_width = 11'd3;

  // last pixel index inside a cell
  localparam coord_t cell_last = cell_size - 11'd1;

  // first pixel of the dark bevel along x or y
  localparam coord_t bevel_start = cell_size - bevel_width;

  localparam rgb_t black = 12'h000;

endpackage

`default_nettype wire

//--- rtl/piece_pkg.sv
`default_nettype none

package piece_pkg;

  // block codes, the upper bit marks a real piece
  typedef enum logic [4:0] {
    block_none = 5'd0,
    block_i    = 5'd16,
    block_o    = 5'd17,
    block_t    = 5'd18,
    block_s    = 5'd19,
    block_z    = 5'd20,
    block_j    = 5'd21,
    block_l    = 5'd22
  } block_e;

  typedef logic [1:0] rot_t;

  // grid column or row, wraps modulo 32
  typedef logic [4:0] cell_t;

  localparam video_pkg::rgb_t red_light    = 12'hfab;
  localparam video_pkg::rgb_t red_dark     = 12'h800;
  localparam video_pkg::rgb_t red_normal   = 12'hf00;
  localparam video_pkg::rgb_t yellow_light  = 12'hff8;
  localparam video_pkg::rgb_t yellow_dark   = 12'hbb6;
  localparam video_pkg::rgb_t yellow_normal = 12'hff0;
  localparam video_pkg::rgb_t pink_light   = 12'he8e;
  localparam video_pkg::rgb_t pink_dark    = 12'h808;
  localparam video_pkg::rgb_t pink_normal  = 12'hf0f;
  localparam video_pkg::rgb_t blue_light   = 12'h0bf;
  localparam video_pkg::rgb_t blue_dark    = 12'h008;
  localparam video_pkg::rgb_t blue_normal  = 12'h00f;
  localparam video_pkg::rgb_t green_light  = 12'h9f9;
  localparam video_pkg::rgb_t green_dark   = 12'h080;
  localparam video_pkg::rgb_t green_normal = 12'h0f0;
  localparam video_pkg::rgb_t cyan_light   = 12'hcff;
  localparam video_pkg::rgb_t cyan_dark    = 12'h0cf;
  localparam video_pkg::rgb_t cyan_normal  = 12'h0ff;

  // piece sequencer states
  typedef enum logic {
    seq_idle,
    seq_pending
  } seq_state_e;

endpackage

`default_nettype wire

//--- rtl/overlay_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// one pixel of the raster stream with its timing
interface vga_if;
  video_pkg::coord_t hcount;
  video_pkg::coord_t vcount;
  logic              hsync;
  logic              vsync;
  logic              hblnk;
  logic              vblnk;
  video_pkg::rgb_t   rgb;

  modport src (output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);
  modport snk (input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);
endinterface

// decoded piece, cells listed in hit priority order
interface shape_if;
  piece_pkg::cell_t col [4];
  piece_pkg::cell_t row [4];
  video_pkg::rgb_t  light;
  video_pkg::rgb_t  dark;
  video_pkg::rgb_t  normal;
  // no piece on screen, cells carry no meaning
  logic             absent;

  modport prod (output col, row, light, dark, normal, absent);
  modport cons (input col, row, light, dark, normal, absent);
endinterface

`default_nettype wire

//--- rtl/piece_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module piece_sequencer (
  input  wire logic               pclk,
  input  wire logic               rst,
  input  wire logic               piece_valid,
  input  piece_pkg::block_e       piece_block,
  input  piece_pkg::rot_t         piece_rot,
  input  piece_pkg::cell_t        piece_xpos,
  input  piece_pkg::cell_t        piece_ypos,
  input  wire logic               vblnk,
  output logic                    piece_ready,
  output piece_pkg::block_e       cur_block,
  output piece_pkg::rot_t         cur_rot,
  output piece_pkg::cell_t        cur_xpos,
  output piece_pkg::cell_t        cur_ypos
);

  piece_pkg::seq_state_e state;
  logic                  vblnk_prev;
  logic                  frame_start;

  piece_pkg::block_e     pend_block;
  piece_pkg::rot_t       pend_rot;
  piece_pkg::cell_t      pend_xpos;
  piece_pkg::cell_t      pend_ypos;

  // first cycle of vertical blanking
  assign frame_start = vblnk && !vblnk_prev;

  // one slot, so accept only while nothing waits for the frame edge
  assign piece_ready = (state == piece_pkg::seq_idle);

  always_ff @(posedge pclk or posedge rst) begin
    if (rst) begin
      state      <= piece_pkg::seq_idle;
      vblnk_prev <= 1'b0;
      cur_block  <= piece_pkg::block_none;
      cur_rot    <= '0;
      cur_xpos   <= '0;
      cur_ypos   <= '0;
    end else begin
      vblnk_prev <= vblnk;
      case (state)
        piece_pkg::seq_idle: begin
          if (piece_valid) begin
            state <= piece_pkg::seq_pending;
          end
        end
        piece_pkg::seq_pending: begin
          if (frame_start) begin
            state     <= piece_pkg::seq_idle;
            cur_block <= pend_block;
            cur_rot   <= pend_rot;
            cur_xpos  <= pend_xpos;
            cur_ypos  <= pend_ypos;
          end
        end
        default: state <= piece_pkg::seq_idle;
      endcase
    end
  end

  always_ff @(posedge pclk) begin
    if (piece_valid && piece_ready) begin
      pend_block <= piece_block;
      pend_rot   <= piece_rot;
      pend_xpos  <= piece_xpos;
      pend_ypos  <= piece_ypos;
    end
  end

endmodule

`default_nettype wire

//--- rtl/shape_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module shape_decoder (
  input  piece_pkg::block_e cur_block,
  input  piece_pkg::rot_t   cur_rot,
  input  piece_pkg::cell_t  cur_xpos,
  input  piece_pkg::cell_t  cur_ypos,
  shape_if.prod             shape
);

  // cell offsets from the piece position, cells 1 to 4
  int dc [4];
  int dr [4];

  always_comb begin
    dc           = '{0, 0, 0, 0};
    dr           = '{0, 0, 0, 0};
    shape.light  = piece_pkg::red_light;
    shape.dark   = piece_pkg::red_dark;
    shape.normal = piece_pkg::red_normal;
    shape.absent = 1'b0;
    case (cur_block)
      piece_pkg::block_i: begin
        if (!cur_rot[0]) begin
          dc = '{-1, 0, 1, 2};
        end else begin
          dr = '{-1, 0, 1, 2};
        end
      end
      piece_pkg::block_o: begin
        shape.light  = piece_pkg::yellow_light;
        shape.dark   = piece_pkg::yellow_dark;
        shape.normal = piece_pkg::yellow_normal;
        dc = '{0, 1, 0, 1};
        dr = '{0, 0, 1, 1};
      end
      piece_pkg::block_t: begin
        shape.light  = piece_pkg::pink_light;
        shape.dark   = piece_pkg::pink_dark;
        shape.normal = piece_pkg::pink_normal;
        case (cur_rot)
          2'd0: begin
            dc = '{-1, 0, 1, 0};
            dr = '{0, 0, 0, 1};
          end
          2'd1: begin
            dc = '{0, 0, -1, 0};
            dr = '{-1, 0, 0, 1};
          end
          2'd2: begin
            dc = '{-1, 0, 1, 0};
            dr = '{0, 0, 0, -1};
          end
          default: begin
            dc = '{0, 0, 1, 0};
            dr = '{-1, 0, 0, 1};
          end
        endcase
      end
      piece_pkg::block_s: begin
        shape.light  = piece_pkg::green_light;
        shape.dark   = piece_pkg::green_dark;
        shape.normal = piece_pkg::green_normal;
        if (!cur_rot[0]) begin
          dc = '{-1, 0, 0, 1};
          dr = '{1, 0, 1, 0};
        end else begin
          dc = '{0, 0, 1, 1};
          dr = '{-1, 0, 0, 1};
        end
      end
      piece_pkg::block_z: begin
        shape.light  = piece_pkg::blue_light;
        shape.dark   = piece_pkg::blue_dark;
        shape.normal = piece_pkg::blue_normal;
        if (!cur_rot[0]) begin
          dc = '{-1, 0, 0, 1};
          dr = '{0, 0, 1, 1};
        end else begin
          dc = '{0, 0, -1, -1};
          dr = '{-1, 0, 0, 1};
        end
      end
      piece_pkg::block_j: begin
        shape.light  = piece_pkg::cyan_light;
        shape.dark   = piece_pkg::cyan_dark;
        shape.normal = piece_pkg::cyan_normal;
        case (cur_rot)
          2'd0: begin
            dc = '{-1, 0, 1, 1};
            dr = '{0, 0, 0, 1};
          end
          2'd1: begin
            dc = '{0, 0, 0, 1};
            dr = '{-1, 0, 1, -1};
          end
          2'd2: begin
            dc = '{-1, -1, 1, 0};
            dr = '{-1, 0, 0, 0};
          end
          default: begin
            dc = '{0, 0, -1, 0};
            dr = '{-1, 0, 1, 1};
          end
        endcase
      end
      piece_pkg::block_l: begin
        case (cur_rot)
          2'd0: begin
            dc = '{-1, 0, 1, -1};
            dr = '{0, 0, 0, 1};
          end
          2'd1: begin
            dc = '{0, 0, 0, 1};
            dr = '{-1, 0, 1, 1};
          end
          2'd2: begin
            dc = '{1, -1, 1, 0};
            dr = '{-1, 0, 0, 0};
          end
          default: begin
            dc = '{0, 0, -1, 0};
            dr = '{-1, 0, -1, 1};
          end
        endcase
      end
      // none and any undefined code draw nothing
      default: shape.absent = 1'b1;
    endcase
  end

  // positions wrap at the 5-bit grid boundary
  for (genvar i = 0; i < 4; i++) begin : g_cell
    assign shape.col[i] = cur_xpos + piece_pkg::cell_t'(dc[i]);
    assign shape.row[i] = cur_ypos + piece_pkg::cell_t'(dr[i]);
  end

endmodule

`default_nettype wire

//--- rtl/cell_shader.sv
`timescale 1ns/1ps
`default_nettype none

module cell_shader (
  input  wire logic pclk,
  input  wire logic rst,
  vga_if.snk        pix_in,
  shape_if.cons     shape,
  vga_if.src        pix_out
);

  video_pkg::coord_t x0 [4];
  video_pkg::coord_t y0 [4];
  video_pkg::coord_t dx [4];
  video_pkg::coord_t dy [4];
  logic [3:0]        hit;
  logic [3:0]        light;
  logic [3:0]        dark;
  video_pkg::rgb_t   rgb_nxt;

  for (genvar i = 0; i < 4; i++) begin : g_cell
    assign x0[i] = video_pkg::grid_x0
                 + video_pkg::cell_size * video_pkg::coord_t'(shape.col[i]);
    assign y0[i] = video_pkg::grid_y0
                 + video_pkg::cell_size * video_pkg::coord_t'(shape.row[i]);

    // pixels left of or above the cell wrap to large values and miss
    assign dx[i] = pix_in.hcount - x0[i];
    assign dy[i] = pix_in.vcount - y0[i];

    assign hit[i] = !shape.absent && (dx[i] < video_pkg::cell_size)
                  && (dy[i] < video_pkg::cell_size);

    // top-left bevel, the corner triangles split along the diagonal
    assign light[i] = (dx[i] < video_pkg::bevel_width
                       && dy[i] < video_pkg::cell_last - dx[i])
                    || (dy[i] < video_pkg::bevel_width && dx[i] != '0
                       && dx[i] < video_pkg::cell_last - dy[i]);

    assign dark[i] = (dx[i] >= video_pkg::bevel_start
                      && dy[i] >= video_pkg::cell_size - dx[i])
                   || (dy[i] >= video_pkg::bevel_start
                      && dx[i] > video_pkg::cell_last - dy[i]);
  end

  always_comb begin
    rgb_nxt = pix_in.rgb;
    // walk from cell 4 down so the lowest hit cell wins
    for (int i = 3; i >= 0; i--) begin
      if (hit[i]) begin
        if (light[i]) begin
          rgb_nxt = shape.light;
        end else if (dark[i]) begin
          rgb_nxt = shape.dark;
        end else begin
          rgb_nxt = shape.normal;
        end
      end
    end
    if (pix_in.hblnk || pix_in.vblnk) begin
      rgb_nxt = video_pkg::black;
    end
  end

  always_ff @(posedge pclk or posedge rst) begin
    if (rst) begin
      pix_out.hcount <= '0;
      pix_out.vcount <= '0;
      pix_out.hsync  <= 1'b0;
      pix_out.vsync  <= 1'b0;
      pix_out.hblnk  <= 1'b0;
      pix_out.vblnk  <= 1'b0;
      pix_out.rgb    <= '0;
    end else begin
      pix_out.hcount <= pix_in.hcount;
      pix_out.vcount <= pix_in.vcount;
      pix_out.hsync  <= pix_in.hsync;
      pix_out.vsync  <= pix_in.vsync;
      pix_out.hblnk  <= pix_in.hblnk;
      pix_out.vblnk  <= pix_in.vblnk;
      pix_out.rgb    <= rgb_nxt;
    end
  end

endmodule

`default_nettype wire

//--- rtl/tetris_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module tetris_overlay (
  input  wire logic         pclk,
  input  wire logic         rst,

  input  wire logic         piece_valid,
  output logic              piece_ready,
  input  piece_pkg::block_e piece_block,
  input  piece_pkg::rot_t   piece_rot,
  input  piece_pkg::cell_t  piece_xpos,
  input  piece_pkg::cell_t  piece_ypos,

  input  video_pkg::coord_t hcount_in,
  input  video_pkg::coord_t vcount_in,
  input  wire logic         hsync_in,
  input  wire logic         vsync_in,
  input  wire logic         hblnk_in,
  input  wire logic         vblnk_in,
  input  video_pkg::rgb_t   rgb_in,

  output video_pkg::coord_t hcount_out,
  output video_pkg::coord_t vcount_out,
  output logic              hsync_out,
  output logic              vsync_out,
  output logic              hblnk_out,
  output logic              vblnk_out,
  output video_pkg::rgb_t   rgb_out
);

  piece_pkg::block_e cur_block;
  piece_pkg::rot_t   cur_rot;
  piece_pkg::cell_t  cur_xpos;
  piece_pkg::cell_t  cur_ypos;

  vga_if   pix_in_bus ();
  vga_if   pix_out_bus ();
  shape_if shape_bus ();

  assign pix_in_bus.hcount = hcount_in;
  assign pix_in_bus.vcount = vcount_in;
  assign pix_in_bus.hsync  = hsync_in;
  assign pix_in_bus.vsync  = vsync_in;
  assign pix_in_bus.hblnk  = hblnk_in;
  assign pix_in_bus.vblnk  = vblnk_in;
  assign pix_in_bus.rgb    = rgb_in;

  assign hcount_out = pix_out_bus.hcount;
  assign vcount_out = pix_out_bus.vcount;
  assign hsync_out  = pix_out_bus.hsync;
  assign vsync_out  = pix_out_bus.vsync;
  assign hblnk_out  = pix_out_bus.hblnk;
  assign vblnk_out  = pix_out_bus.vblnk;
  assign rgb_out    = pix_out_bus.rgb;

  // piece swap follows the unregistered vblank input
  piece_sequencer i_sequencer (
    .pclk        (pclk),
    .rst         (rst),
    .piece_valid (piece_valid),
    .piece_block (piece_block),
    .piece_rot   (piece_rot),
    .piece_xpos  (piece_xpos),
    .piece_ypos  (piece_ypos),
    .vblnk       (vblnk_in),
    .piece_ready (piece_ready),
    .cur_block   (cur_block),
    .cur_rot     (cur_rot),
    .cur_xpos    (cur_xpos),
    .cur_ypos    (cur_ypos)
  );

  shape_decoder i_decoder (
    .cur_block (cur_block),
    .cur_rot   (cur_rot),
    .cur_xpos  (cur_xpos),
    .cur_ypos  (cur_ypos),
    .shape     (shape_bus.prod)
  );

  cell_shader i_shader (
    .pclk    (pclk),
    .rst     (rst),
    .pix_in  (pix_in_bus.snk),
    .shape   (shape_bus.cons),
    .pix_out (pix_out_bus.src)
  );

endmodule

`default_nettype wire

//--- test/overlay_assert.sv
`timescale 1ns/1ps
`default_nettype none

module overlay_assert (
  input wire logic             pclk,
  input wire logic             rst,
  input wire logic             piece_valid,
  input wire logic             piece_ready,
  input wire logic             vblnk,
  input wire logic             vblnk_prev,
  input piece_pkg::seq_state_e state
);

  // a transfer fills the only slot, so ready drops on the next cycle
  ready_drops_on_transfer : assert property (@(posedge pclk) disable iff (rst)
    (piece_valid && piece_ready) |=> (state == piece_pkg::seq_pending && !piece_ready))
    else $error("piece_ready still high after a transfer");

  // ready comes back only with the frame start that empties the slot
  ready_rises_on_frame_start : assert property (@(posedge pclk) disable iff (rst)
    $rose(piece_ready) |-> $past(vblnk && !vblnk_prev))
    else $error("piece_ready rose without a frame start");

  // moves only on a transfer or on the first cycle of vblank
  state_change_cause : assert property (@(posedge pclk) disable iff (rst)
    (state != $past(state))
      |-> $past((piece_valid && piece_ready) || (vblnk && !vblnk_prev)))
    else $error("sequencer state changed without handshake or frame start");

endmodule

bind piece_sequencer overlay_assert i_assert (
  .pclk        (pclk),
  .rst         (rst),
  .piece_valid (piece_valid),
  .piece_ready (piece_ready),
  .vblnk       (vblnk),
  .vblnk_prev  (vblnk_prev),
  .state       (state)
);

`default_nettype wire

//--- test/overlay_checker.sv
`timescale 1ns/1ps
`default_nettype none

module overlay_checker (
  input wire logic          pclk,
  input wire logic          rst,
  input wire logic          piece_valid,
  input wire logic          piece_ready,
  input piece_pkg::block_e  piece_block,
  input piece_pkg::rot_t    piece_rot,
  input piece_pkg::cell_t   piece_xpos,
  input piece_pkg::cell_t   piece_ypos,
  input video_pkg::coord_t  hcount_in,
  input video_pkg::coord_t  vcount_in,
  input wire logic          hsync_in,
  input wire logic          vsync_in,
  input wire logic          hblnk_in,
  input wire logic          vblnk_in,
  input video_pkg::rgb_t    rgb_in,
  input video_pkg::coord_t  hcount_out,
  input video_pkg::coord_t  vcount_out,
  input wire logic          hsync_out,
  input wire logic          vsync_out,
  input wire logic          hblnk_out,
  input wire logic          vblnk_out,
  input video_pkg::rgb_t    rgb_out,
  output int                error_count
);

  int checks;
  int errors;
  int tests;
  int test_checks;
  int test_errors;

  // sequencer model
  logic              m_pending;
  logic              m_vblnk_prev;
  piece_pkg::block_e cur_blk;
  piece_pkg::block_e pend_blk;
  piece_pkg::rot_t   cur_rot;
  piece_pkg::rot_t   pend_rot;
  piece_pkg::cell_t  cur_x;
  piece_pkg::cell_t  cur_y;
  piece_pkg::cell_t  pend_x;
  piece_pkg::cell_t  pend_y;

  video_pkg::coord_t exp_hcount;
  video_pkg::coord_t exp_vcount;
  logic              exp_hsync;
  logic              exp_vsync;
  logic              exp_hblnk;
  logic              exp_vblnk;
  video_pkg::rgb_t   exp_rgb;

  initial begin
    checks = 0;
    errors = 0;
    tests = 0;
    test_checks = 0;
    test_errors = 0;
  end

  assign error_count = errors;

  // column then row offset of each cell, cells 1 to 4
  function automatic int cell_offset(input piece_pkg::block_e blk,
                                     input piece_pkg::rot_t rot, input int k);
    int t [8];
    t = '{0, 0, 0, 0, 0, 0, 0, 0};
    case (blk)
      piece_pkg::block_i: begin
        case (rot[0])
          1'b0: t = '{-1, 0, 0, 0, 1, 0, 2, 0};
          default: t = '{0, -1, 0, 0, 0, 1, 0, 2};
        endcase
      end
      piece_pkg::block_o: t = '{0, 0, 1, 0, 0, 1, 1, 1};
      piece_pkg::block_t: begin
        case (rot)
          2'd0: t = '{-1, 0, 0, 0, 1, 0, 0, 1};
          2'd1: t = '{0, -1, 0, 0, -1, 0, 0, 1};
          2'd2: t = '{-1, 0, 0, 0, 1, 0, 0, -1};
          default: t = '{0, -1, 0, 0, 1, 0, 0, 1};
        endcase
      end
      piece_pkg::block_s: begin
        case (rot[0])
          1'b0: t = '{-1, 1, 0, 0, 0, 1, 1, 0};
          default: t = '{0, -1, 0, 0, 1, 0, 1, 1};
        endcase
      end
      piece_pkg::block_z: begin
        case (rot[0])
          1'b0: t = '{-1, 0, 0, 0, 0, 1, 1, 1};
          default: t = '{0, -1, 0, 0, -1, 0, -1, 1};
        endcase
      end
      piece_pkg::block_j: begin
        case (rot)
          2'd0: t = '{-1, 0, 0, 0, 1, 0, 1, 1};
          2'd1: t = '{0, -1, 0, 0, 0, 1, 1, -1};
          2'd2: t = '{-1, -1, -1, 0, 1, 0, 0, 0};
          default: t = '{0, -1, 0, 0, -1, 1, 0, 1};
        endcase
      end
      piece_pkg::block_l: begin
        case (rot)
          2'd0: t = '{-1, 0, 0, 0, 1, 0, -1, 1};
          2'd1: t = '{0, -1, 0, 0, 0, 1, 1, 1};
          2'd2: t = '{1, -1, -1, 0, 1, 0, 0, 0};
          default: t = '{0, -1, 0, 0, -1, -1, 0, 1};
        endcase
      end
      default: t = '{0, 0, 0, 0, 0, 0, 0, 0};
    endcase
    return t[k];
  endfunction

  // shade 0 light, 1 dark, 2 normal
  function automatic video_pkg::rgb_t shade_colour(input piece_pkg::block_e blk,
                                                   input int shade);
    video_pkg::rgb_t pal [3];
    case (blk)
      piece_pkg::block_o: pal = '{piece_pkg::yellow_light, piece_pkg::yellow_dark,
                                  piece_pkg::yellow_normal};
      piece_pkg::block_t: pal = '{piece_pkg::pink_light, piece_pkg::pink_dark,
                                  piece_pkg::pink_normal};
      piece_pkg::block_s: pal = '{piece_pkg::green_light, piece_pkg::green_dark,
                                  piece_pkg::green_normal};
      piece_pkg::block_z: pal = '{piece_pkg::blue_light, piece_pkg::blue_dark,
                                  piece_pkg::blue_normal};
      piece_pkg::block_j: pal = '{piece_pkg::cyan_light, piece_pkg::cyan_dark,
                                  piece_pkg::cyan_normal};
      default: pal = '{piece_pkg::red_light, piece_pkg::red_dark, piece_pkg::red_normal};
    endcase
    return pal[shade];
  endfunction

  function automatic video_pkg::rgb_t expected_rgb(
    input piece_pkg::block_e blk, input piece_pkg::rot_t rot,
    input piece_pkg::cell_t xpos, input piece_pkg::cell_t ypos,
    input video_pkg::coord_t hc, input video_pkg::coord_t vc,
    input logic blank, input video_pkg::rgb_t bg);
    int col;
    int row;
    int dx;
    int dy;
    int cs;
    int bw;
    logic found;
    video_pkg::rgb_t result;
    cs = int'(video_pkg::cell_size);
    bw = int'(video_pkg::bevel_width);
    found = 1'b0;
    result = bg;
    if (blk < piece_pkg::block_i || blk > piece_pkg::block_l) begin
      found = 1'b1;
    end
    for (int k = 0; k < 4; k++) begin
      col = (int'(xpos) + cell_offset(blk, rot, 2 * k) + 32) % 32;
      row = (int'(ypos) + cell_offset(blk, rot, 2 * k + 1) + 32) % 32;
      dx = int'(hc) - (int'(video_pkg::grid_x0) + cs * col);
      dy = int'(vc) - (int'(video_pkg::grid_y0) + cs * row);
      if (!found && dx >= 0 && dx < cs && dy >= 0 && dy < cs) begin
        found = 1'b1;
        if ((dx < bw && dy < cs - 1 - dx) || (dy < bw && dx > 0 && dx < cs - 1 - dy)) begin
          result = shade_colour(blk, 0);
        end else if ((dx >= cs - bw && dy >= cs - dx)
                     || (dy >= cs - bw && dx > cs - 1 - dy)) begin
          result = shade_colour(blk, 1);
        end else begin
          result = shade_colour(blk, 2);
        end
      end
    end
    if (blank) begin
      result = video_pkg::black;
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    test_checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("ERROR at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s finished: %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic report();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
  endtask

  always @(posedge pclk or posedge rst) begin
    if (rst) begin
      m_pending    <= 1'b0;
      m_vblnk_prev <= 1'b0;
      cur_blk      <= piece_pkg::block_none;
      cur_rot      <= '0;
      cur_x        <= '0;
      cur_y        <= '0;
      exp_hcount   <= '0;
      exp_vcount   <= '0;
      exp_hsync    <= 1'b0;
      exp_vsync    <= 1'b0;
      exp_hblnk    <= 1'b0;
      exp_vblnk    <= 1'b0;
      exp_rgb      <= '0;
    end else begin
      exp_hcount   <= hcount_in;
      exp_vcount   <= vcount_in;
      exp_hsync    <= hsync_in;
      exp_vsync    <= vsync_in;
      exp_hblnk    <= hblnk_in;
      exp_vblnk    <= vblnk_in;
      exp_rgb      <= expected_rgb(cur_blk, cur_rot, cur_x, cur_y, hcount_in, vcount_in,
                                   hblnk_in || vblnk_in, rgb_in);
      m_vblnk_prev <= vblnk_in;
      if (!m_pending) begin
        if (piece_valid) begin
          m_pending <= 1'b1;
          pend_blk  <= piece_block;
          pend_rot  <= piece_rot;
          pend_x    <= piece_xpos;
          pend_y    <= piece_ypos;
        end
      end else if (vblnk_in && !m_vblnk_prev) begin
        m_pending <= 1'b0;
        cur_blk   <= pend_blk;
        cur_rot   <= pend_rot;
        cur_x     <= pend_x;
        cur_y     <= pend_y;
      end
    end
  end

  // outputs settle half a cycle after the edge
  always @(negedge pclk) begin
    check_value("hcount_out", 32'(hcount_out), 32'(exp_hcount));
    check_value("vcount_out", 32'(vcount_out), 32'(exp_vcount));
    check_value("hsync_out", 32'(hsync_out), 32'(exp_hsync));
    check_value("vsync_out", 32'(vsync_out), 32'(exp_vsync));
    check_value("hblnk_out", 32'(hblnk_out), 32'(exp_hblnk));
    check_value("vblnk_out", 32'(vblnk_out), 32'(exp_vblnk));
    check_value("rgb_out", 32'(rgb_out), 32'(exp_rgb));
    check_value("piece_ready", 32'(piece_ready), 32'(!m_pending));
  end

endmodule

`default_nettype wire

//--- test/tb_tetris_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tetris_overlay;

  localparam int n_pass = 400;
  localparam int n_shape = 160;
  localparam int n_defer = 120;
  localparam int burst = 4;
  localparam int max_wait = 40;
  localparam int planned_cycles = 30 + n_pass + 28 * (max_wait + burst + n_shape + 6)
                                + 2 * n_defer + max_wait + burst + 20;
  localparam int watchdog_ns = 2 * planned_cycles * 10;

  logic              pclk;
  logic              rst;
  logic              piece_valid;
  logic              piece_ready;
  piece_pkg::block_e piece_block;
  piece_pkg::rot_t   piece_rot;
  piece_pkg::cell_t  piece_xpos;
  piece_pkg::cell_t  piece_ypos;
  video_pkg::coord_t hcount_in;
  video_pkg::coord_t vcount_in;
  logic              hsync_in;
  logic              vsync_in;
  logic              hblnk_in;
  logic              vblnk_in;
  video_pkg::rgb_t   rgb_in;
  video_pkg::coord_t hcount_out;
  video_pkg::coord_t vcount_out;
  logic              hsync_out;
  logic              vsync_out;
  logic              hblnk_out;
  logic              vblnk_out;
  video_pkg::rgb_t   rgb_out;

  int                check_errors;
  int                tb_errors;
  // grid cell around which pixels are aimed
  piece_pkg::cell_t  tgt_x;
  piece_pkg::cell_t  tgt_y;

  tetris_overlay i_dut (
    .pclk (pclk), .rst (rst),
    .piece_valid (piece_valid), .piece_ready (piece_ready),
    .piece_block (piece_block), .piece_rot (piece_rot),
    .piece_xpos (piece_xpos), .piece_ypos (piece_ypos),
    .hcount_in (hcount_in), .vcount_in (vcount_in),
    .hsync_in (hsync_in), .vsync_in (vsync_in),
    .hblnk_in (hblnk_in), .vblnk_in (vblnk_in), .rgb_in (rgb_in),
    .hcount_out (hcount_out), .vcount_out (vcount_out),
    .hsync_out (hsync_out), .vsync_out (vsync_out),
    .hblnk_out (hblnk_out), .vblnk_out (vblnk_out), .rgb_out (rgb_out)
  );

  overlay_checker i_checker (
    .pclk (pclk), .rst (rst),
    .piece_valid (piece_valid), .piece_ready (piece_ready),
    .piece_block (piece_block), .piece_rot (piece_rot),
    .piece_xpos (piece_xpos), .piece_ypos (piece_ypos),
    .hcount_in (hcount_in), .vcount_in (vcount_in),
    .hsync_in (hsync_in), .vsync_in (vsync_in),
    .hblnk_in (hblnk_in), .vblnk_in (vblnk_in), .rgb_in (rgb_in),
    .hcount_out (hcount_out), .vcount_out (vcount_out),
    .hsync_out (hsync_out), .vsync_out (vsync_out),
    .hblnk_out (hblnk_out), .vblnk_out (vblnk_out), .rgb_out (rgb_out),
    .error_count (check_errors)
  );

  initial begin
    pclk = 1'b0;
    forever begin
      #5 pclk = ~pclk;
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog: run did not finish within %0d ns", watchdog_ns);
    $display("Done: errors found");
    $finish;
  end

  // random pixels, mostly on the cells around the target
  task automatic drive_pixels(input int n, input bit aimed, input bit blanks,
                              input bit in_vblank);
    int col;
    int row;
    for (int i = 0; i < n; i++) begin
      @(posedge pclk);
      #1;
      if (aimed && ($urandom % 8 != 0)) begin
        col = (int'(tgt_x) + int'($urandom % 4) - 1 + 32) % 32;
        row = (int'(tgt_y) + int'($urandom % 4) - 1 + 32) % 32;
        hcount_in = video_pkg::coord_t'(201 + 35 * col + int'($urandom % 35));
        vcount_in = video_pkg::coord_t'(10 + 35 * row + int'($urandom % 35));
      end else begin
        hcount_in = video_pkg::coord_t'($urandom);
        vcount_in = video_pkg::coord_t'($urandom);
      end
      rgb_in = video_pkg::rgb_t'($urandom);
      hsync_in = 1'($urandom);
      vsync_in = 1'($urandom);
      hblnk_in = blanks && ($urandom % 4 == 0);
      vblnk_in = in_vblank || (blanks && ($urandom % 8 == 0));
    end
  endtask

  task automatic offer_piece(input piece_pkg::block_e blk, input piece_pkg::rot_t rot,
                             input piece_pkg::cell_t x, input piece_pkg::cell_t y);
    int waited;
    waited = 0;
    @(posedge pclk);
    #1;
    piece_valid = 1'b1;
    piece_block = blk;
    piece_rot = rot;
    piece_xpos = x;
    piece_ypos = y;
    hblnk_in = 1'b0;
    vblnk_in = 1'b0;
    while (!piece_ready && waited < max_wait) begin
      @(posedge pclk);
      #1;
      waited++;
    end
    if (!piece_ready) begin
      tb_errors++;
      $display("piece_ready stayed low for %0d cycles, piece not accepted", waited);
    end
    @(posedge pclk);
    #1;
    piece_valid = 1'b0;
  endtask

  task automatic settle();
    repeat (3) @(posedge pclk);
    #1;
  endtask

  initial begin
    void'($urandom(32'h9dcf));
    tb_errors = 0;
    rst = 1'b1;
    piece_valid = 1'b0;
    piece_block = piece_pkg::block_none;
    piece_rot = '0;
    piece_xpos = '0;
    piece_ypos = '0;
    hcount_in = '0;
    vcount_in = '0;
    hsync_in = 1'b0;
    vsync_in = 1'b0;
    hblnk_in = 1'b0;
    vblnk_in = 1'b0;
    rgb_in = '0;
    tgt_x = '0;
    tgt_y = '0;
    // raster keeps moving under reset while the outputs stay cleared
    drive_pixels(10, 1'b0, 1'b1, 1'b0);
    rst = 1'b0;
    settle();
    i_checker.end_test("reset");

    // no piece yet, so the background passes or blanks to black
    drive_pixels(n_pass, 1'b0, 1'b1, 1'b0);
    settle();
    i_checker.end_test("passthrough");

    for (int b = 16; b <= 22; b++) begin
      for (int r = 0; r < 4; r++) begin
        tgt_x = (r == 0) ? 5'd0 : piece_pkg::cell_t'($urandom);
        tgt_y = (r == 3) ? 5'd31 : piece_pkg::cell_t'($urandom);
        offer_piece(piece_pkg::block_e'(5'(b)), piece_pkg::rot_t'(r), tgt_x, tgt_y);
        drive_pixels(burst, 1'b0, 1'b0, 1'b1);
        drive_pixels(n_shape, 1'b1, 1'b0, 1'b0);
      end
    end
    settle();
    i_checker.end_test("shapes");

    // new piece waits in the sequencer while the old one stays on screen
    offer_piece(piece_pkg::block_t, 2'd1, tgt_x + 5'd1, tgt_y);
    drive_pixels(n_defer, 1'b1, 1'b0, 1'b0);
    drive_pixels(burst, 1'b0, 1'b0, 1'b1);
    tgt_x = tgt_x + 5'd1;
    drive_pixels(n_defer, 1'b1, 1'b0, 1'b0);
    settle();
    i_checker.end_test("deferred update");

    i_checker.report();
    if (check_errors == 0 && tb_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
rtl/video_pkg.sv
rtl/piece_pkg.sv
rtl/overlay_ifs.sv
rtl/piece_sequencer.sv
rtl/shape_decoder.sv
rtl/cell_shader.sv
rtl/tetris_overlay.sv
test/overlay_assert.sv
test/overlay_checker.sv
test/tb_tetris_overlay.sv

//--- Makefile
sim:
	verilator --binary --timing --assert --top-module tb_tetris_overlay -f flist.f
	./obj_dir/Vtb_tetris_overlay > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Done: errors found" sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
